// File: mc_channel_adapter.f
mc_adapter_pkg.sv
mc_sync_fifo.sv
mc_req_decode.sv
mc_mem_issue.sv
mc_rsp_return.sv
mc_channel_adapter.sv
mc_mem_model.sv
tb_mc_channel_adapter.sv

// File: tb_mc_channel_adapter.sv
// Testbench for the memory-channel adapter with a randomly stalling memory model
`timescale 1ns/1ns
`default_nettype none

module tb_mc_channel_adapter;

  import mc_adapter_pkg::*;

  localparam int n_rand      = 60;
  localparam int n_bp        = 12;
  localparam int fifo_depth  = 2 ** req_depth_w;
  localparam int worst_stall = 16;
  localparam int timeout_cycles =
    (2**mem_addr_w + n_rand + n_bp + fifo_depth) * worst_stall + 200;
  localparam int cmd_w = 4 + mem_addr_w + be_w + data_w;
  localparam int rsp_w = data_w + 1 + mdata_w;
  localparam int cat_init = 0;
  localparam int cat_cmd  = 1;
  localparam int cat_rsp  = 2;
  localparam int cat_flow = 3;

  logic                   emif_usr_clk = 1'b0;
  logic                   reset_n_eclk;
  logic                   read;
  logic                   write;
  logic                   write_poison;
  logic [host_addr_w-1:0] address;
  logic [host_addr_w-1:0] base_addr;
  logic                   base_addr_vld;
  logic [be_w-1:0]        byteenable;
  logic [data_w-1:0]      writedata;
  logic [mdata_w-1:0]     req_mdata;
  logic                   ready;
  logic                   host_readdatavalid;
  logic [data_w-1:0]      host_readdata;
  logic                   host_read_poison;
  logic [mdata_w-1:0]     host_rsp_mdata;
  logic                   mem_ready;
  logic                   mem_read;
  logic                   mem_write;
  logic                   mem_write_partial;
  logic                   mem_write_poison;
  logic [mem_addr_w-1:0]  mem_address;
  logic [data_w-1:0]      mem_writedata;
  logic [be_w-1:0]        mem_byteenable;
  logic                   mem_readdatavalid;
  logic [data_w-1:0]      mem_readdata;
  logic                   mem_read_poison;
  logic                   ram_init_done;
  logic                   stall;
  logic [1:0]             lat;
  logic                   hold;

  logic [31:0]       stim_lfsr;
  logic [31:0]       mem_lfsr;
  int                err_cnt [4];
  int                cycles;
  int                init_cnt;
  int                pending;
  int                bp_accepts;
  logic              init_seen;
  logic [data_w-1:0] ref_data [2**mem_addr_w];
  logic              ref_poison [2**mem_addr_w];
  logic [cmd_w-1:0]  cmd_q [$];
  logic [rsp_w-1:0]  rsp_q [$];

  mc_channel_adapter mc_channel_adapter_i (.*);

  mc_mem_model mem_model_i (.*);

  always #20 emif_usr_clk = ~emif_usr_clk;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
    logic [31:0] val;
    val = '0;
    repeat (n) begin
      val   = {val[30:0], state[0]};
      state = {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
    end
    return val;
  endfunction

  task automatic note_mismatch(input int cat, input string sig, input logic [63:0] got,
                               input logic [63:0] exp);
    err_cnt[cat]++;
    $display("MISMATCH t=%0t %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
  endtask

  task automatic note_failure(input int cat, input string what);
    err_cnt[cat]++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  task automatic finish_run();
    int total;
    total = err_cnt[cat_init] + err_cnt[cat_cmd] + err_cnt[cat_rsp] + err_cnt[cat_flow];
    $display("Errors: init %0d, command %0d, response %0d, flow %0d",
             err_cnt[cat_init], err_cnt[cat_cmd], err_cnt[cat_rsp], err_cnt[cat_flow]);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // Holds one request on the host port until the adapter takes it
  task automatic send_req(input logic is_wr, input logic [host_addr_w-1:0] addr,
                          input logic [be_w-1:0] be, input logic [data_w-1:0] data,
                          input logic psn, input logic [mdata_w-1:0] tag);
    read         <= !is_wr;
    write        <= is_wr;
    address      <= addr;
    byteenable   <= be;
    writedata    <= data;
    write_poison <= psn;
    req_mdata    <= tag;
    do @(posedge emif_usr_clk); while (!ready);
    read  <= 1'b0;
    write <= 1'b0;
  endtask

  task automatic send_random();
    logic                   is_wr;
    logic [be_w-1:0]        be;
    logic [host_addr_w-1:0] addr;
    logic [data_w-1:0]      data;
    logic                   psn;
    logic [mdata_w-1:0]     tag;
    is_wr = take_bits(stim_lfsr, 1);
    be    = take_bits(stim_lfsr, 1) ? '1 : be_w'(take_bits(stim_lfsr, be_w));
    addr  = host_addr_w'(take_bits(stim_lfsr, host_addr_w));
    data  = take_bits(stim_lfsr, data_w);
    psn   = (take_bits(stim_lfsr, 3) == 32'd0);
    tag   = mdata_w'(take_bits(stim_lfsr, mdata_w));
    send_req(is_wr, addr, be, data, psn, tag);
  endtask

  // About one cycle in four stalls, plus a forced stall for back-pressure
  always @(posedge emif_usr_clk) begin
    stall <= hold || (take_bits(mem_lfsr, 2) == 32'd0);
    lat   <= 2'(take_bits(mem_lfsr, 2));
  end

  always @(posedge emif_usr_clk) begin
    cycles = cycles + 1;
    if (cycles == timeout_cycles) begin
      note_failure(cat_flow, "timeout, requests did not drain in time");
      finish_run();
    end
  end

  // ------------------------------
  // Protocol properties
  // ------------------------------
  assert property (@(posedge emif_usr_clk) disable iff (!reset_n_eclk)
    !ram_init_done |-> !ready)
    else note_failure(cat_init, "ready high before ram_init_done");

  assert property (@(posedge emif_usr_clk) disable iff (!reset_n_eclk)
    !base_addr_vld |-> !ready)
    else note_failure(cat_flow, "ready high while base_addr_vld low");

  assert property (@(posedge emif_usr_clk) disable iff (!reset_n_eclk)
    pending <= fifo_depth)
    else note_failure(cat_flow, "more requests waiting than the request FIFO holds");

  assert property (@(posedge emif_usr_clk) disable iff (!reset_n_eclk)
    mem_readdatavalid |=> host_readdatavalid)
    else note_failure(cat_rsp, "read response not returned one cycle after memory data");

  // ------------------------------
  // Scoreboard
  // ------------------------------
  always @(posedge emif_usr_clk) begin
    logic                  exp_wr;
    logic                  exp_rd;
    logic                  exp_part;
    logic                  exp_psn;
    logic [mem_addr_w-1:0] exp_addr;
    logic [be_w-1:0]       exp_be;
    logic [data_w-1:0]     exp_data;
    logic [mdata_w-1:0]    exp_tag;
    logic [mem_addr_w-1:0] acc_addr;
    if (reset_n_eclk) begin
      if (!ram_init_done && mem_ready) begin
        assert (mem_write && !mem_read && !mem_write_partial)
          else note_failure(cat_init, "initialisation command is not a plain write");
        assert (mem_address == mem_addr_w'(init_cnt))
          else note_mismatch(cat_init, "mem_address", mem_address, init_cnt);
        assert (mem_writedata == '0)
          else note_mismatch(cat_init, "mem_writedata", mem_writedata, 0);
        assert (mem_byteenable == '1)
          else note_mismatch(cat_init, "mem_byteenable", mem_byteenable, {be_w{1'b1}});
        init_cnt++;
      end
      if (ram_init_done && !init_seen) begin
        init_seen = 1'b1;
        assert (init_cnt == 2**mem_addr_w)
          else note_mismatch(cat_init, "init write count", init_cnt, 2**mem_addr_w);
      end
      if (ram_init_done && !base_addr_vld && pending == 0) begin
        assert (!mem_read && !mem_write)
          else note_failure(cat_flow, "command issued while base_addr_vld low");
      end
      if (ram_init_done && mem_ready && (mem_read || mem_write)) begin
        if (cmd_q.size() == 0) begin
          note_failure(cat_cmd, "memory command with no accepted request");
        end else begin
          {exp_wr, exp_rd, exp_part, exp_psn, exp_addr, exp_be, exp_data} = cmd_q.pop_front();
          pending--;
          assert ({mem_write, mem_read} == {exp_wr, exp_rd})
            else note_mismatch(cat_cmd, "mem_write/mem_read", {mem_write, mem_read},
                               {exp_wr, exp_rd});
          assert (mem_address == exp_addr)
            else note_mismatch(cat_cmd, "mem_address", mem_address, exp_addr);
          assert (mem_write_partial == exp_part)
            else note_mismatch(cat_cmd, "mem_write_partial", mem_write_partial, exp_part);
          if (exp_wr) begin
            assert (mem_byteenable == exp_be)
              else note_mismatch(cat_cmd, "mem_byteenable", mem_byteenable, exp_be);
            assert (mem_writedata == exp_data)
              else note_mismatch(cat_cmd, "mem_writedata", mem_writedata, exp_data);
            assert (mem_write_poison == exp_psn)
              else note_mismatch(cat_cmd, "mem_write_poison", mem_write_poison, exp_psn);
          end
        end
      end
      // Expected memory contents follow the host requests in acceptance order
      if (ready && (read || write)) begin
        acc_addr = mem_addr_w'(address - base_addr);
        exp_part = write && (byteenable != '1);
        cmd_q.push_back({write, read, exp_part, write_poison, acc_addr, byteenable, writedata});
        pending++;
        if (read) begin
          rsp_q.push_back({ref_data[acc_addr], ref_poison[acc_addr], req_mdata});
        end else begin
          for (int i = 0; i < be_w; i++) begin
            if (byteenable[i]) begin
              ref_data[acc_addr][i*sym_w +: sym_w] = writedata[i*sym_w +: sym_w];
            end
          end
          ref_poison[acc_addr] = write_poison;
        end
      end
      if (host_readdatavalid) begin
        if (rsp_q.size() == 0) begin
          note_failure(cat_rsp, "read response with no outstanding read");
        end else begin
          {exp_data, exp_psn, exp_tag} = rsp_q.pop_front();
          assert (host_readdata == exp_data)
            else note_mismatch(cat_rsp, "host_readdata", host_readdata, exp_data);
          assert (host_read_poison == exp_psn)
            else note_mismatch(cat_rsp, "host_read_poison", host_read_poison, exp_psn);
          assert (host_rsp_mdata == exp_tag)
            else note_mismatch(cat_rsp, "host_rsp_mdata", host_rsp_mdata, exp_tag);
        end
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    stim_lfsr     = 32'd66221;
    mem_lfsr      = 32'd66221;
    reset_n_eclk  = 1'b0;
    read          = 1'b0;
    write         = 1'b0;
    write_poison  = 1'b0;
    address       = '0;
    base_addr     = 16'h1240;
    // The base is valid from the start, so only ram_init_done keeps ready low
    base_addr_vld = 1'b1;
    byteenable    = '0;
    writedata     = '0;
    req_mdata     = '0;
    stall         = 1'b0;
    lat           = 2'd0;
    hold          = 1'b0;
    cycles        = 0;
    init_cnt      = 0;
    pending       = 0;
    init_seen     = 1'b0;
    foreach (err_cnt[i]) err_cnt[i] = 0;
    foreach (ref_data[i]) begin
      ref_data[i]   = '0;
      ref_poison[i] = 1'b0;
    end
    repeat (3) @(posedge emif_usr_clk);
    reset_n_eclk <= 1'b1;
    while (!ram_init_done) @(posedge emif_usr_clk);

    // A read held on the port must not get in while the window base is unknown
    base_addr_vld <= 1'b0;
    read          <= 1'b1;
    repeat (6) @(posedge emif_usr_clk);
    read          <= 1'b0;
    base_addr_vld <= 1'b1;

    repeat (n_rand) send_random();
    while (cmd_q.size() != 0) @(posedge emif_usr_clk);

    // With the memory stalled the request FIFO fills and ready falls
    hold <= 1'b1;
    repeat (3) @(posedge emif_usr_clk);
    bp_accepts = 0;
    write        <= 1'b1;
    write_poison <= 1'b0;
    byteenable   <= '1;
    address      <= base_addr;
    writedata    <= take_bits(stim_lfsr, data_w);
    for (int i = 0; i < n_bp; i++) begin
      @(posedge emif_usr_clk);
      if (ready) begin
        bp_accepts++;
        address      <= base_addr + host_addr_w'(bp_accepts);
        writedata    <= take_bits(stim_lfsr, data_w);
        write_poison <= !write_poison;
      end
    end
    assert (bp_accepts == fifo_depth)
      else note_mismatch(cat_flow, "accepted under back-pressure", bp_accepts, fifo_depth);
    assert (!ready)
      else note_failure(cat_flow, "ready still high with the request FIFO full");
    write <= 1'b0;
    hold  <= 1'b0;

    for (int i = 0; i < fifo_depth; i++) begin
      send_req(1'b0, base_addr + host_addr_w'(i), '1, '0, 1'b0, mdata_w'(i + 40));
    end
    while (cmd_q.size() != 0 || rsp_q.size() != 0) @(posedge emif_usr_clk);
    repeat (4) @(posedge emif_usr_clk);
    finish_run();
  end

endmodule

`default_nettype wire

// File: mc_mem_model.sv
// Testbench memory model with stall-driven ready and in-order variable read latency
`timescale 1ns/1ns
`default_nettype none

module mc_mem_model (
  input  logic                                  emif_usr_clk,
  input  logic                                  reset_n_eclk,
  input  logic                                  stall,
  input  logic [1:0]                            lat,
  output logic                                  mem_ready,
  input  logic                                  mem_read,
  input  logic                                  mem_write,
  input  logic                                  mem_write_poison,
  input  logic [mc_adapter_pkg::mem_addr_w-1:0] mem_address,
  input  logic [mc_adapter_pkg::data_w-1:0]     mem_writedata,
  input  logic [mc_adapter_pkg::be_w-1:0]       mem_byteenable,
  output logic                                  mem_readdatavalid,
  output logic [mc_adapter_pkg::data_w-1:0]     mem_readdata,
  output logic                                  mem_read_poison
);

  import mc_adapter_pkg::*;

  logic [data_w-1:0] words [2**mem_addr_w];
  logic              poison_bits [2**mem_addr_w];
  logic [data_w:0]   rsp_q [$];
  int                due_q [$];
  int                cycle;
  int                last_due;
  int                due;

  assign mem_ready = !stall;

  always @(posedge emif_usr_clk) begin
    mem_readdatavalid <= 1'b0;
    if (!reset_n_eclk) begin
      cycle    = 0;
      last_due = 0;
      rsp_q.delete();
      due_q.delete();
    end else begin
      cycle = cycle + 1;
      if (mem_ready && mem_write) begin
        for (int i = 0; i < be_w; i++) begin
          if (mem_byteenable[i]) begin
            words[mem_address][i*sym_w +: sym_w] = mem_writedata[i*sym_w +: sym_w];
          end
        end
        poison_bits[mem_address] = mem_write_poison;
      end
      // Returns stay in issue order, so a later read never overtakes an earlier one
      if (mem_ready && mem_read) begin
        due = cycle + 1 + int'(lat);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        rsp_q.push_back({poison_bits[mem_address], words[mem_address]});
        due_q.push_back(due);
        last_due = due;
      end
      if (due_q.size() != 0 && due_q[0] == cycle) begin
        mem_readdatavalid <= 1'b1;
        {mem_read_poison, mem_readdata} <= rsp_q.pop_front();
        void'(due_q.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

// File: mc_channel_adapter.sv
// Memory-channel adapter top joining request decode, queue, issue and response return
`timescale 1ns/1ns
`default_nettype none

module mc_channel_adapter (
  input  logic                                   emif_usr_clk,
  input  logic                                   reset_n_eclk,
  // Host request port
  input  logic                                   read,
  input  logic                                   write,
  input  logic                                   write_poison,
  input  logic [mc_adapter_pkg::host_addr_w-1:0] address,
  input  logic [mc_adapter_pkg::host_addr_w-1:0] base_addr,
  input  logic                                   base_addr_vld,
  input  logic [mc_adapter_pkg::be_w-1:0]        byteenable,
  input  logic [mc_adapter_pkg::data_w-1:0]      writedata,
  input  logic [mc_adapter_pkg::mdata_w-1:0]     req_mdata,
  output logic                                   ready,
  // Host response port
  output logic                                   host_readdatavalid,
  output logic [mc_adapter_pkg::data_w-1:0]      host_readdata,
  output logic                                   host_read_poison,
  output logic [mc_adapter_pkg::mdata_w-1:0]     host_rsp_mdata,
  // Memory command port
  input  logic                                   mem_ready,
  output logic                                   mem_read,
  output logic                                   mem_write,
  output logic                                   mem_write_partial,
  output logic                                   mem_write_poison,
  output logic [mc_adapter_pkg::mem_addr_w-1:0]  mem_address,
  output logic [mc_adapter_pkg::data_w-1:0]      mem_writedata,
  output logic [mc_adapter_pkg::be_w-1:0]        mem_byteenable,
  input  logic                                   mem_readdatavalid,
  input  logic [mc_adapter_pkg::data_w-1:0]      mem_readdata,
  input  logic                                   mem_read_poison,
  // Status
  output logic                                   ram_init_done
);

  import mc_adapter_pkg::*;

  logic                  fifo_wr_en;
  logic [req_word_w-1:0] fifo_wr_data;
  logic                  fifo_rd_en;
  logic [req_word_w-1:0] fifo_rd_data;
  logic                  fifo_empty;
  logic                  fifo_full;
  logic                  read_issued;
  logic [mdata_w-1:0]    issued_mdata;

  mc_req_decode req_decode_i (
    .read          (read),
    .write         (write),
    .write_poison  (write_poison),
    .address       (address),
    .base_addr     (base_addr),
    .base_addr_vld (base_addr_vld),
    .byteenable    (byteenable),
    .writedata     (writedata),
    .req_mdata     (req_mdata),
    .ram_init_done (ram_init_done),
    .fifo_full     (fifo_full),
    .ready         (ready),
    .fifo_wr_en    (fifo_wr_en),
    .fifo_wr_data  (fifo_wr_data)
  );

  mc_sync_fifo #(
    .width   (req_word_w),
    .depth_w (req_depth_w)
  ) req_fifo_i (
    .emif_usr_clk (emif_usr_clk),
    .reset_n_eclk (reset_n_eclk),
    .wr_en        (fifo_wr_en),
    .wr_data      (fifo_wr_data),
    .rd_en        (fifo_rd_en),
    .rd_data      (fifo_rd_data),
    .empty        (fifo_empty),
    .full         (fifo_full)
  );

  mc_mem_issue mem_issue_i (
    .emif_usr_clk      (emif_usr_clk),
    .reset_n_eclk      (reset_n_eclk),
    .fifo_rd_data      (fifo_rd_data),
    .fifo_empty        (fifo_empty),
    .fifo_rd_en        (fifo_rd_en),
    .mem_ready         (mem_ready),
    .mem_read          (mem_read),
    .mem_write         (mem_write),
    .mem_write_partial (mem_write_partial),
    .mem_write_poison  (mem_write_poison),
    .mem_address       (mem_address),
    .mem_writedata     (mem_writedata),
    .mem_byteenable    (mem_byteenable),
    .ram_init_done     (ram_init_done),
    .read_issued       (read_issued),
    .issued_mdata      (issued_mdata)
  );

  mc_rsp_return rsp_return_i (
    .emif_usr_clk       (emif_usr_clk),
    .reset_n_eclk       (reset_n_eclk),
    .read_issued        (read_issued),
    .issued_mdata       (issued_mdata),
    .mem_readdatavalid  (mem_readdatavalid),
    .mem_readdata       (mem_readdata),
    .mem_read_poison    (mem_read_poison),
    .host_readdatavalid (host_readdatavalid),
    .host_readdata      (host_readdata),
    .host_read_poison   (host_read_poison),
    .host_rsp_mdata     (host_rsp_mdata)
  );

endmodule

`default_nettype wire

// File: mc_rsp_return.sv
// Read-tag tracking and registered read response toward the host
`timescale 1ns/1ns
`default_nettype none

module mc_rsp_return (
  input  logic                               emif_usr_clk,
  input  logic                               reset_n_eclk,
  input  logic                               read_issued,
  input  logic [mc_adapter_pkg::mdata_w-1:0] issued_mdata,
  input  logic                               mem_readdatavalid,
  input  logic [mc_adapter_pkg::data_w-1:0]  mem_readdata,
  input  logic                               mem_read_poison,
  output logic                               host_readdatavalid,
  output logic [mc_adapter_pkg::data_w-1:0]  host_readdata,
  output logic                               host_read_poison,
  output logic [mc_adapter_pkg::mdata_w-1:0] host_rsp_mdata
);

  import mc_adapter_pkg::*;

  logic [mdata_w-1:0] tag_head;
  logic               tag_empty;

  // ------------------------------
  // Tag queue
  // ------------------------------
  // Same depth as the request queue, so it cannot fill and full is left open
  mc_sync_fifo #(
    .width   (mdata_w),
    .depth_w (req_depth_w)
  ) tag_fifo_i (
    .emif_usr_clk (emif_usr_clk),
    .reset_n_eclk (reset_n_eclk),
    .wr_en        (read_issued),
    .wr_data      (issued_mdata),
    .rd_en        (mem_readdatavalid),
    .rd_data      (tag_head),
    .empty        (tag_empty),
    .full         ()
  );

  always_ff @(posedge emif_usr_clk) begin
    if (!reset_n_eclk) begin
      host_readdatavalid <= 1'b0;
    end else begin
      host_readdatavalid <= mem_readdatavalid;
    end
  end

  // Memory returns in issue order, so the oldest tag matches this data
  always_ff @(posedge emif_usr_clk) begin
    if (mem_readdatavalid) begin
      host_readdata    <= mem_readdata;
      host_read_poison <= mem_read_poison;
      host_rsp_mdata   <= tag_head;
    end
  end

  // Read data only comes back for reads the issue stage has handed over
  assert property (@(posedge emif_usr_clk) disable iff (!reset_n_eclk)
    mem_readdatavalid |-> !tag_empty)
    else $error("mc_rsp_return: read data with no outstanding read");

endmodule

`default_nettype wire

// File: mc_mem_issue.sv
// Zero-initialisation sequencer and memory command multiplexer
`timescale 1ns/1ns
`default_nettype none

module mc_mem_issue (
  input  logic                                  emif_usr_clk,
  input  logic                                  reset_n_eclk,
  input  logic [mc_adapter_pkg::req_word_w-1:0] fifo_rd_data,
  input  logic                                  fifo_empty,
  output logic                                  fifo_rd_en,
  input  logic                                  mem_ready,
  output logic                                  mem_read,
  output logic                                  mem_write,
  output logic                                  mem_write_partial,
  output logic                                  mem_write_poison,
  output logic [mc_adapter_pkg::mem_addr_w-1:0] mem_address,
  output logic [mc_adapter_pkg::data_w-1:0]     mem_writedata,
  output logic [mc_adapter_pkg::be_w-1:0]       mem_byteenable,
  output logic                                  ram_init_done,
  output logic                                  read_issued,
  output logic [mc_adapter_pkg::mdata_w-1:0]    issued_mdata
);

  import mc_adapter_pkg::*;

  logic [mem_addr_w-1:0] init_addr;

  logic                  head_write;
  logic                  head_partial;
  logic                  head_read;
  logic                  head_poison;
  logic [be_w-1:0]       head_be;
  logic [mem_addr_w-1:0] head_addr;
  logic [data_w-1:0]     head_data;
  logic [mdata_w-1:0]    head_mdata;

  // ------------------------------
  // Zero-initialisation sequencer
  // ------------------------------
  always_ff @(posedge emif_usr_clk) begin
    if (!reset_n_eclk) begin
      init_addr     <= '0;
      ram_init_done <= 1'b0;
    end else if (!ram_init_done && mem_ready) begin
      init_addr <= init_addr + 1'b1;
      if (init_addr == init_last_addr) begin
        ram_init_done <= 1'b1;
      end
    end
  end

  assign {head_write, head_partial, head_read, head_poison,
          head_be, head_addr, head_data, head_mdata} = fifo_rd_data;

  // ------------------------------
  // Command multiplexer
  // ------------------------------
  always_comb begin
    if (ram_init_done) begin
      mem_write         = !fifo_empty && head_write;
      mem_read          = !fifo_empty && head_read;
      mem_write_partial = !fifo_empty && head_partial;
      mem_write_poison  = head_poison;
      mem_address       = head_addr;
      mem_writedata     = head_data;
      mem_byteenable    = head_be;
    end else begin
      mem_write         = 1'b1;
      mem_read          = 1'b0;
      mem_write_partial = 1'b0;
      mem_write_poison  = 1'b0;
      mem_address       = init_addr;
      mem_writedata     = '0;
      mem_byteenable    = {be_w{1'b1}};
    end
  end

  // The head leaves the queue on the cycle the memory takes it
  assign fifo_rd_en   = ram_init_done && !fifo_empty && mem_ready;
  assign read_issued  = fifo_rd_en && head_read;
  assign issued_mdata = head_mdata;

  // A stalled command keeps its kind and address until the memory takes it
  assert property (@(posedge emif_usr_clk) disable iff (!reset_n_eclk)
    (mem_read || mem_write) && !mem_ready |=>
      $stable(mem_read) && $stable(mem_write) && $stable(mem_address))
    else $error("mc_mem_issue: stalled command changed before mem_ready");

endmodule

`default_nettype wire

// File: mc_req_decode.sv
// Host request acceptance, base-address translation and partial-write tagging
`timescale 1ns/1ns
`default_nettype none

module mc_req_decode (
  input  logic                              read,
  input  logic                              write,
  input  logic                              write_poison,
  input  logic [mc_adapter_pkg::host_addr_w-1:0] address,
  input  logic [mc_adapter_pkg::host_addr_w-1:0] base_addr,
  input  logic                              base_addr_vld,
  input  logic [mc_adapter_pkg::be_w-1:0]   byteenable,
  input  logic [mc_adapter_pkg::data_w-1:0] writedata,
  input  logic [mc_adapter_pkg::mdata_w-1:0] req_mdata,
  input  logic                              ram_init_done,
  input  logic                              fifo_full,
  output logic                              ready,
  output logic                              fifo_wr_en,
  output logic [mc_adapter_pkg::req_word_w-1:0] fifo_wr_data
);

  import mc_adapter_pkg::*;

  logic [host_addr_w-1:0] addr_offset;
  logic                   partial;

  // Host is held off until memory is zeroed and the window base is known
  assign ready      = !fifo_full && ram_init_done && base_addr_vld;
  assign fifo_wr_en = ready && (read || write);

  // ------------------------------
  // Address translation
  // ------------------------------
  // Upper bits of the offset fall away, the memory only sees its own window
  assign addr_offset = address - base_addr;

  // Any missing byte lane makes this a read-modify-write candidate downstream
  assign partial = write && (byteenable != {be_w{1'b1}});

  assign fifo_wr_data = {write, partial, read, write_poison, byteenable,
                         addr_offset[mem_addr_w-1:0], writedata, req_mdata};

  // One request is either a read or a write, never both
  always_comb begin
    assert #0 (!(fifo_wr_en && read && write))
      else $error("mc_req_decode: request with both read and write");
  end

endmodule

`default_nettype wire

// File: mc_sync_fifo.sv
// Synchronous first-word-fall-through FIFO built as a circular buffer
`timescale 1ns/1ns
`default_nettype none

module mc_sync_fifo #(
  parameter int width   = 8,
  parameter int depth_w = 3
) (
  input  logic             emif_usr_clk,
  input  logic             reset_n_eclk,
  input  logic             wr_en,
  input  logic [width-1:0] wr_data,
  input  logic             rd_en,
  output logic [width-1:0] rd_data,
  output logic             empty,
  output logic             full
);

  localparam int depth = 2 ** depth_w;

  logic [width-1:0]   mem [depth];
  logic [depth_w-1:0] wr_ptr;
  logic [depth_w-1:0] rd_ptr;
  logic [depth_w:0]   count;

  // Storage has no reset; only entries below the count are ever read
  always_ff @(posedge emif_usr_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge emif_usr_clk) begin
    if (!reset_n_eclk) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The head entry is visible without a read strobe
  assign rd_data = mem[rd_ptr];
  assign empty   = (count == '0);
  assign full    = (count == depth[depth_w:0]);

  assert property (@(posedge emif_usr_clk) disable iff (!reset_n_eclk) !(wr_en && full))
    else $error("mc_sync_fifo: write while full");

  assert property (@(posedge emif_usr_clk) disable iff (!reset_n_eclk) !(rd_en && empty))
    else $error("mc_sync_fifo: read while empty");

endmodule

`default_nettype wire

// File: mc_adapter_pkg.sv
// Memory-channel adapter shared widths, queue depth and initialisation limits
`default_nettype none

package mc_adapter_pkg;

  // ------------------------------
  // Host and memory word geometry
  // ------------------------------
  localparam int host_addr_w = 16;
  localparam int mem_addr_w  = 6;
  localparam int data_w      = 32;
  localparam int sym_w       = 8;
  localparam int be_w        = data_w / sym_w;
  localparam int mdata_w     = 6;

  // ------------------------------
  // Request queue
  // ------------------------------
  localparam int req_depth_w = 3;

  // Write, partial, read and poison flags, then byte enables, address, data and tag
  localparam int req_word_w  = 4 + be_w + mem_addr_w + data_w + mdata_w;

  // ------------------------------
  // Zero initialisation
  // ------------------------------
  // The sequencer stops after this word has been written
  localparam logic [mem_addr_w-1:0] init_last_addr = {mem_addr_w{1'b1}};

endpackage

`default_nettype wire
